//--- hw/vision_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types for the binary-vision front end.
// frames up to 1280x720, cell grid fixed at 16x10 with 8x5 sampling.
//////////////////////////////////////////////////////////////////////
package vision_pkg;

    localparam int MAX_CELLS_X   = 80;  // 1280 / 16.
    localparam int MAX_CELL_ROWS = 72;  // 720 / 10.

    localparam int CELL_W   = 16;
    localparam int CELL_H   = 10;
    localparam int SAMPLE_W = 8;
    localparam int SAMPLE_H = 5;
    localparam int MAJORITY = 20;       // half of the 40 sampled pixels.

    typedef logic [7:0]             luma_t;
    typedef logic [MAX_CELLS_X-1:0] cell_row_t;
    typedef logic [6:0]             cell_idx_t;

    typedef struct packed {
        logic       vsync;
        logic       hsync;
        logic       de;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
        logic bin;
    } bin_pix_t;

    // win[0] is the current row, win[4] the row four lines above.
    typedef struct packed {
        logic       vsync;
        logic       hsync;
        logic       de;
        logic [4:0] win;
    } col_win_t;

    typedef struct packed {
        logic      req;
        cell_idx_t idx;
        cell_row_t data;
    } mem_req_t;

    typedef struct packed {
        cell_idx_t idx;
        cell_row_t row;
    } cell_out_t;

endpackage

//--- hw/pixel_binarize.sv
//////////////////////////////////////////////////////////////////////
// luma is (r + 2g + b) / 4, compared against a run-time threshold.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pixel_binarize (
    input  logic                 clk,
    input  logic                 rstn,
    input  vision_pkg::pixel_t   pix_in,
    input  vision_pkg::luma_t    threshold,
    output vision_pkg::bin_pix_t bin_out
);

    logic [9:0]        luma_sum;
    vision_pkg::luma_t luma;

    assign luma_sum = {2'b00, pix_in.r}
                    + {1'b0, pix_in.g, 1'b0}
                    + {2'b00, pix_in.b};
    assign luma     = luma_sum[9:2];  // divide by four.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bin_out <= '0;
        end else begin
            bin_out.vsync <= pix_in.vsync;
            bin_out.hsync <= pix_in.hsync;
            bin_out.de    <= pix_in.de;
            bin_out.bin   <= luma >= threshold;
        end
    end

endmodule

//--- hw/row_window.sv
//////////////////////////////////////////////////////////////////////
// four line buffers of H_ACT bits; the window is valid only under de.
// the buffers are not cleared at vsync and hold the previous frame.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module row_window #(
    parameter int H_ACT = 1280
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  vision_pkg::bin_pix_t bin_in,
    output vision_pkg::col_win_t win_out
);

    localparam int COL_W = $clog2(H_ACT);

    logic [COL_W-1:0] col;
    logic             de_d;
    logic             de_fall;
    logic [H_ACT-1:0] cur_row;
    logic [H_ACT-1:0] line_buf [4];

    assign de_fall = de_d & ~bin_in.de;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col     <= '0;
            de_d    <= 1'b0;
            win_out <= '0;
        end else begin
            de_d          <= bin_in.de;
            col           <= bin_in.de ? col + 1'b1 : '0;
            win_out.vsync <= bin_in.vsync;
            win_out.hsync <= bin_in.hsync;
            win_out.de    <= bin_in.de;
            win_out.win   <= bin_in.de ? {line_buf[3][col], line_buf[2][col],
                                          line_buf[1][col], line_buf[0][col],
                                          bin_in.bin} : 5'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bin_in.de) begin
            cur_row[col] <= bin_in.bin;
        end
        if (de_fall) begin  // line done, shift down one row.
            line_buf[0] <= cur_row;
            line_buf[1] <= line_buf[0];
            line_buf[2] <= line_buf[1];
            line_buf[3] <= line_buf[2];
        end
    end

endmodule

//--- hw/compress_window.sv
//////////////////////////////////////////////////////////////////////
// one bit per 16x10 cell, decided on the 8x5 sample area at its top-left.
// H_ACT and V_ACT must be multiples of 16 and 10.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module compress_window #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  vision_pkg::col_win_t win_in,
    output vision_pkg::mem_req_t wr_req,
    input  logic                 wr_gnt,
    output logic                 frame_done
);

    localparam int CELLS_X   = H_ACT / vision_pkg::CELL_W;
    localparam int CELL_ROWS = V_ACT / vision_pkg::CELL_H;
    localparam int CX_W      = $clog2(CELLS_X + 1);

    logic                  de_d;
    logic                  de_fall;
    logic                  sample_row;
    logic [3:0]            row_cnt;   // line within the block.
    logic [3:0]            col_cnt;   // pixel within the cell.
    logic [CX_W-1:0]       cell_x;
    vision_pkg::cell_idx_t blk_cnt;
    logic [2:0]            col_sum;
    logic [5:0]            sum;       // max 40.
    logic                  wr_last;
    vision_pkg::cell_row_t row_word;

    assign de_fall    = de_d & ~win_in.de;
    assign sample_row = row_cnt == 4'(vision_pkg::SAMPLE_H - 1);
    assign col_sum    = {2'b00, win_in.win[0]} + {2'b00, win_in.win[1]}
                      + {2'b00, win_in.win[2]} + {2'b00, win_in.win[3]}
                      + {2'b00, win_in.win[4]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            de_d       <= 1'b0;
            row_cnt    <= '0;
            col_cnt    <= '0;
            cell_x     <= '0;
            blk_cnt    <= '0;
            sum        <= '0;
            row_word   <= '0;
            wr_req     <= '0;
            wr_last    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            de_d       <= win_in.de;
            frame_done <= 1'b0;
            if (wr_gnt) begin
                wr_req.req <= 1'b0;
                frame_done <= wr_last;  // last cell row is stored.
            end
            if (win_in.vsync) begin
                row_cnt  <= '0;
                col_cnt  <= '0;
                cell_x   <= '0;
                blk_cnt  <= '0;
                sum      <= '0;
                row_word <= '0;
            end else begin
                if (win_in.de) begin
                    col_cnt <= col_cnt + 1'b1;
                    if (sample_row && col_cnt < 4'(vision_pkg::SAMPLE_W)) begin
                        sum <= sum + {3'b000, col_sum};
                    end
                    if (col_cnt == 4'(vision_pkg::CELL_W - 1)) begin
                        col_cnt <= '0;
                        cell_x  <= cell_x + 1'b1;
                        sum     <= '0;
                        if (sample_row) begin
                            row_word[cell_x] <= sum >= 6'(vision_pkg::MAJORITY);
                        end
                    end
                end else begin
                    col_cnt <= '0;
                    cell_x  <= '0;
                end

                ////////////////////////////////////////////////////////////////////
                // end of line: advance the block row, post the cell row.
                ////////////////////////////////////////////////////////////////////
                if (de_fall) begin
                    row_cnt <= (row_cnt == 4'(vision_pkg::CELL_H - 1)) ? '0 : row_cnt + 1'b1;
                    if (sample_row) begin
                        wr_req.req  <= 1'b1;
                        wr_req.idx  <= blk_cnt;
                        wr_req.data <= row_word;
                        wr_last     <= blk_cnt == vision_pkg::cell_idx_t'(CELL_ROWS - 1);
                        blk_cnt     <= blk_cnt + 1'b1;
                        row_word    <= '0;
                    end
                end
            end
        end
    end

endmodule

//--- hw/cell_arbiter.sv
//////////////////////////////////////////////////////////////////////
// round-robin access to a single-port cell memory of 72 rows.
// grants are combinational, read data follows one cycle after grant.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cell_arbiter (
    input  logic                  clk,
    input  logic                  rstn,
    input  vision_pkg::mem_req_t  wr_req,
    output logic                  wr_gnt,
    input  vision_pkg::mem_req_t  rd_req,
    output logic                  rd_gnt,
    output vision_pkg::cell_row_t rd_data
);

    vision_pkg::cell_row_t mem [vision_pkg::MAX_CELL_ROWS];
    logic                  last_wr;  // write won the last grant.

    // on a tie the side that did not win last time goes first.
    assign wr_gnt = wr_req.req && (!rd_req.req || !last_wr);
    assign rd_gnt = rd_req.req && !wr_gnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_wr <= 1'b0;
        end else if (wr_gnt) begin
            last_wr <= 1'b1;
        end else if (rd_gnt) begin
            last_wr <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // memory port.
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_gnt) begin
            mem[wr_req.idx] <= wr_req.data;
        end
        if (rd_gnt) begin
            rd_data <= mem[rd_req.idx];
        end
    end

endmodule

//--- hw/cell_readout.sv
//////////////////////////////////////////////////////////////////////
// after frame_done, streams cell rows 0..V_ACT/10-1 in order.
// one word leaves per credit, the consumer pulses credit_in to return one.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cell_readout #(
    parameter int V_ACT   = 720,
    parameter int CREDITS = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  frame_done,
    output vision_pkg::mem_req_t  rd_req,
    input  logic                  rd_gnt,
    input  vision_pkg::cell_row_t rd_data,
    output logic                  out_valid,
    output vision_pkg::cell_out_t out_cell,
    input  logic                  credit_in
);

    localparam int CELL_ROWS = V_ACT / vision_pkg::CELL_H;
    localparam int CRD_W     = $clog2(CREDITS + 1);

    typedef enum logic [1:0] {IDLE, READ, WAIT_DATA, SEND} state_t;

    state_t                state;
    vision_pkg::cell_idx_t idx;
    logic [CRD_W-1:0]      credit_cnt;
    logic                  send;

    assign send        = (state == SEND) && (credit_cnt != '0);
    assign rd_req.req  = state == READ;
    assign rd_req.idx  = idx;
    assign rd_req.data = '0;  // read only.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_cnt <= CRD_W'(CREDITS);
        end else begin
            case ({send, credit_in})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            idx       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            case (state)
                IDLE: if (frame_done) begin
                    idx   <= '0;
                    state <= READ;
                end
                READ: if (rd_gnt) state <= WAIT_DATA;
                WAIT_DATA: state <= SEND;  // rd_data lands now.
                SEND: if (send) begin
                    idx   <= idx + 1'b1;
                    state <= (idx == vision_pkg::cell_idx_t'(CELL_ROWS - 1)) ? IDLE : READ;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_DATA) begin
            out_cell.idx <= idx;
            out_cell.row <= rd_data;
        end
    end

endmodule

//--- hw/binary_vision_top.sv
//////////////////////////////////////////////////////////////////////
// binary-vision front end, pixel stream in and cell rows out.
// the pixel input has no back-pressure, only the readout is credited.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module binary_vision_top #(
    parameter int H_ACT   = 1280,
    parameter int V_ACT   = 720,
    parameter int CREDITS = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  vision_pkg::pixel_t    pix_in,
    input  vision_pkg::luma_t     threshold,
    output logic                  out_valid,
    output vision_pkg::cell_out_t out_cell,
    input  logic                  credit_in
);

    vision_pkg::bin_pix_t  bin_pix;
    vision_pkg::col_win_t  col_win;
    vision_pkg::mem_req_t  wr_req;
    vision_pkg::mem_req_t  rd_req;
    vision_pkg::cell_row_t rd_data;
    logic                  wr_gnt;
    logic                  rd_gnt;
    logic                  frame_done;

    pixel_binarize u_pixel_binarize (
        .clk(clk), .rstn(rstn), .pix_in(pix_in), .threshold(threshold), .bin_out(bin_pix)
    );

    row_window #(.H_ACT(H_ACT)) u_row_window (
        .clk(clk), .rstn(rstn), .bin_in(bin_pix), .win_out(col_win)
    );

    compress_window #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_compress_window (
        .clk(clk), .rstn(rstn), .win_in(col_win),
        .wr_req(wr_req), .wr_gnt(wr_gnt), .frame_done(frame_done)
    );

    cell_arbiter u_cell_arbiter (
        .clk(clk), .rstn(rstn), .wr_req(wr_req), .wr_gnt(wr_gnt),
        .rd_req(rd_req), .rd_gnt(rd_gnt), .rd_data(rd_data)
    );

    cell_readout #(.V_ACT(V_ACT), .CREDITS(CREDITS)) u_cell_readout (
        .clk(clk), .rstn(rstn), .frame_done(frame_done),
        .rd_req(rd_req), .rd_gnt(rd_gnt), .rd_data(rd_data),
        .out_valid(out_valid), .out_cell(out_cell), .credit_in(credit_in)
    );

endmodule

//--- dv/tb_tasks.svh
//////////////////////////////////////////////////////////////////////
// directed tests, reference model and compare tasks.
// included inside tb_binary_vision, works on its signals directly.
//////////////////////////////////////////////////////////////////////
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

    task automatic report_failure();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_cell_row(input vision_pkg::cell_row_t got,
                                  input vision_pkg::cell_row_t exp);
        if (got !== exp) begin
            $display("Error: out_cell.row got %h expected %h", got, exp);
            report_failure();
        end
    endtask

    task automatic check_cell_idx(input vision_pkg::cell_idx_t got,
                                  input vision_pkg::cell_idx_t exp);
        if (got !== exp) begin
            $display("Error: out_cell.idx got %h expected %h", got, exp);
            report_failure();
        end
    endtask

    // luma and majority rule on the 8x5 sample area of every cell.
    task automatic build_expected(input vision_pkg::luma_t thr);
        logic [23:0] px;
        int          luma;
        int          cnt;
        for (int cy = 0; cy < CELL_ROWS; cy++) begin
            exp_rows[cy] = '0;
            for (int cx = 0; cx < CELLS_X; cx++) begin
                cnt = 0;
                for (int y = 0; y < vision_pkg::SAMPLE_H; y++) begin
                    for (int x = 0; x < vision_pkg::SAMPLE_W; x++) begin
                        px   = img[cy * vision_pkg::CELL_H + y][cx * vision_pkg::CELL_W + x];
                        luma = (int'(px[23:16]) + 2 * int'(px[15:8]) + int'(px[7:0])) / 4;
                        cnt  = cnt + ((luma >= int'(thr)) ? 1 : 0);
                    end
                end
                exp_rows[cy][cx] = cnt >= vision_pkg::MAJORITY;
            end
        end
    endtask

    task automatic check_frame();
        vision_pkg::cell_out_t got;
        while (got_q.size() < CELL_ROWS) begin
            @(posedge clk);
        end
        for (int i = 0; i < CELL_ROWS; i++) begin
            got = got_q.pop_front();
            check_cell_idx(got.idx, vision_pkg::cell_idx_t'(i));
            check_cell_row(got.row, exp_rows[i]);
        end
    endtask

    task automatic wait_credits_home();
        while (owed != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic frame_and_check(input vision_pkg::luma_t thr);
        build_expected(thr);
        send_frame(thr);
        check_frame();
        wait_credits_home();
    endtask

    //////////////////////////////////////////////////////////////////////
    // images
    //////////////////////////////////////////////////////////////////////
    task automatic fill_uniform(input logic [23:0] rgb);
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                img[y][x] = rgb;
            end
        end
    endtask

    // sample counts 20, 19, 0, 20 by cell column; columns 2, 3 also lit outside.
    task automatic fill_boundary();
        int   n [4];
        int   cx;
        int   k;
        logic lit;
        n = '{20, 19, 0, 20};
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                cx = x / 16;
                k  = (y % 10) * 8 + x % 16;
                if (x % 16 < 8 && y % 10 < 5) begin
                    lit = k < n[cx];
                end else begin
                    lit = cx >= 2;
                end
                img[y][x] = lit ? 24'hffffff : 24'h000000;
            end
        end
    endtask

    // luma 140 or 100 in a cell checkerboard, pixel checkerboard in column 3.
    task automatic fill_luma_pair();
        int v;
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                v = ((x / 16 + y / 10) % 2 == 0) ? 140 : 100;
                if (x / 16 == 3) begin
                    v = ((x + y) % 2 == 0) ? 140 : 100;
                end
                img[y][x] = {8'(v - 4), 8'(v), 8'(v + 4)};
            end
        end
    endtask

    task automatic fill_random();
        logic [31:0] val;
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                rand_bits(24, val);
                img[y][x] = val[23:0];
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_uniform();
        fill_uniform(24'h000000);
        frame_and_check(8'd128);
        fill_uniform(24'hffffff);
        frame_and_check(8'd128);
    endtask

    task automatic test_majority();
        fill_boundary();
        frame_and_check(8'd128);
    endtask

    task automatic test_threshold();
        fill_luma_pair();
        frame_and_check(8'd120);
        frame_and_check(8'd150);
    endtask

    task automatic test_random();
        repeat (3) begin
            fill_random();
            frame_and_check(8'd128);
        end
    endtask

    // first frame uses up all credits, the second must stall until they return.
    task automatic test_backpressure();
        credit_en = 1'b0;
        fill_random();
        build_expected(8'd128);
        send_frame(8'd128);
        check_frame();
        fill_luma_pair();
        build_expected(8'd120);
        send_frame(8'd120);
        repeat (100) @(posedge clk);
        if (got_q.size() != 0) begin
            $display("Readout sent %0d words while no credits were left", got_q.size());
            report_failure();
        end
        credit_en = 1'b1;
        check_frame();
        wait_credits_home();
    endtask

`endif

//--- dv/tb_binary_vision.sv
//////////////////////////////////////////////////////////////////////
// drives 64x40 frames (4x4 cells) with 4 readout credits.
// credits go back to the DUT only while credit_en is set.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_binary_vision;

    localparam int H_ACT        = 64;
    localparam int V_ACT        = 40;
    localparam int CREDITS      = 4;
    localparam int CELLS_X      = H_ACT / vision_pkg::CELL_W;
    localparam int CELL_ROWS    = V_ACT / vision_pkg::CELL_H;
    localparam int CLK_PERIOD   = 4;
    localparam int VS_LEN       = 8;
    localparam int H_GAP        = 16;
    localparam int FRAME_CYCLES = 2 * VS_LEN + V_ACT * (H_ACT + H_GAP);
    localparam int NUM_FRAMES   = 10;
    localparam int TIMEOUT_NS   = NUM_FRAMES * (FRAME_CYCLES + 200) * CLK_PERIOD;

    logic                  clk;
    logic                  rstn;
    vision_pkg::pixel_t    pix_in;
    vision_pkg::luma_t     threshold;
    logic                  out_valid;
    vision_pkg::cell_out_t out_cell;
    logic                  credit_in;

    logic [23:0]           img [V_ACT][H_ACT];  // r, g, b per pixel.
    vision_pkg::cell_row_t exp_rows [CELL_ROWS];
    vision_pkg::cell_out_t got_q [$];
    logic [31:0]           lfsr;
    logic                  credit_en;
    int                    owed;                // credits not yet returned.

    binary_vision_top #(
        .H_ACT(H_ACT), .V_ACT(V_ACT), .CREDITS(CREDITS)
    ) u_binary_vision_top (
        .clk(clk), .rstn(rstn), .pix_in(pix_in), .threshold(threshold),
        .out_valid(out_valid), .out_cell(out_cell), .credit_in(credit_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // frame driver
    //////////////////////////////////////////////////////////////////////
    task automatic drive_blank(input logic vs, input logic hs, input int n);
        vision_pkg::pixel_t p;
        p       = '0;
        p.vsync = vs;
        p.hsync = hs;
        repeat (n) begin
            @(posedge clk);
            pix_in <= p;
        end
    endtask

    task automatic send_frame(input vision_pkg::luma_t thr);
        vision_pkg::pixel_t p;
        @(posedge clk);
        threshold <= thr;
        drive_blank(1'b1, 1'b0, VS_LEN);
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                p = {3'b001, img[y][x]};  // de only.
                @(posedge clk);
                pix_in <= p;
            end
            drive_blank(1'b0, 1'b1, H_GAP);
        end
        drive_blank(1'b1, 1'b0, VS_LEN);
        drive_blank(1'b0, 1'b0, 1);
    endtask

    // words sampled at the falling edge, credits driven on the rising edge.
    initial begin
        credit_in = 1'b0;
        forever begin
            @(negedge clk);
            if (out_valid) begin
                got_q.push_back(out_cell);
                owed++;
            end
            @(posedge clk);
            if (credit_en && owed > 0) begin
                credit_in <= 1'b1;
                owed--;
            end else begin
                credit_in <= 1'b0;
            end
        end
    end

    `include "tb_tasks.svh"

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: cell rows did not arrive within %0d ns", TIMEOUT_NS);
        report_failure();
    end

    initial begin
        rstn      = 1'b0;
        pix_in    = '0;
        threshold = 8'd128;
        credit_en = 1'b1;
        lfsr      = 32'h37555a89;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        test_uniform();
        test_majority();
        test_threshold();
        test_random();
        test_backpressure();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
hw/vision_pkg.sv
hw/pixel_binarize.sv
hw/row_window.sv
hw/compress_window.sv
hw/cell_arbiter.sv
hw/cell_readout.sv
hw/binary_vision_top.sv
dv/tb_binary_vision.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and fail on a reported error.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_binary_vision \
    --Mdir obj_dir -o tb_binary_vision

./obj_dir/tb_binary_vision 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failure"
